//--- uart_reg_bridge.f
hw/uart_bridge_pkg.sv
hw/uart_tx_frame.sv
hw/uart_rx_frame.sv
hw/cmd_sequencer.sv
hw/uart_reg_bridge.sv
tests/uart_reg_bridge_chk.sv
tests/tb_uart_reg_bridge.sv

//--- Makefile
TOP := tb_uart_reg_bridge

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f uart_reg_bridge.f

obj_dir/V$(TOP): uart_reg_bridge.f hw/*.sv tests/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f uart_reg_bridge.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf obj_dir

//--- tests/tb_uart_reg_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uart_reg_bridge;

  localparam int CLKS_PER_BIT     = 8;
  localparam int GAP_CYCLES       = 20;
  localparam int RESP_WAIT_CYCLES = 600;
  localparam int CLK_PERIOD       = 40;
  localparam int FRAME_CYCLES     = uart_bridge_pkg::FRAME_BITS * CLKS_PER_BIT;
  localparam int REPLY_DELAY      = 12;  // Cycles from the stop sample to the reply start.
  // Frames over all tests including one idle frame, and reads that may run out the timer.
  localparam int TEST_FRAMES      = 10;
  localparam int TEST_READS       = 3;
  localparam int WATCHDOG_CYCLES  = 2 * (TEST_FRAMES * FRAME_CYCLES + 2 * GAP_CYCLES
                                         + TEST_READS * RESP_WAIT_CYCLES + 300);
  localparam int WAIT_LIMIT       = 2 * FRAME_CYCLES + GAP_CYCLES + RESP_WAIT_CYCLES + 100;
  localparam int REPLY_GOOD       = 0;
  localparam int REPLY_BAD_PARITY = 1;
  localparam int REPLY_NONE       = 2;

  logic                  clk;
  logic                  rst_n;
  uart_bridge_pkg::cmd_t cmd_in;
  logic                  cmd_vld;
  logic                  rx;
  logic                  tx;
  logic                  cmd_rdy;
  logic                  read_rdy;
  logic [7:0]            read_data;
  logic                  read_err;

  logic [7:0] seen_bytes[$];    // Bytes decoded from tx in order of arrival.
  time        frame_starts[$];  // Falling edge of each start bit on tx.
  int         reply_mode;
  logic [7:0] reply_byte;
  int         read_pulses = 0;
  int         err_cnt     = 0;
  int         chk_cnt     = 0;

  uart_reg_bridge #(
    .CLKS_PER_BIT     (CLKS_PER_BIT),
    .GAP_CYCLES       (GAP_CYCLES),
    .RESP_WAIT_CYCLES (RESP_WAIT_CYCLES)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("The run hung and made no progress within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  always @(negedge clk)
  begin
    if (read_rdy === 1'b1)
    begin
      read_pulses++;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // The parity bit is 1 when the byte holds an even number of ones.
  function automatic logic expected_parity(input logic [7:0] value);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
    begin
      ones += int'(value[i]);
    end
    return (ones % 2 == 0);
  endfunction

  task automatic send_frame(input logic [7:0] value, input logic bad_parity);
    logic [uart_bridge_pkg::FRAME_BITS-1:0] bits;
    bits = {1'b1, expected_parity(value) ^ bad_parity, value, 1'b0};
    for (int i = 0; i < uart_bridge_pkg::FRAME_BITS; i++)
    begin
      rx = bits[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  task automatic wait_cmd_rdy();
    int waited;
    waited = 0;
    while (cmd_rdy !== 1'b1 && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (cmd_rdy !== 1'b1)
    begin
      err_cnt++;
      $display("cmd_rdy did not return high within %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic issue_cmd(input uart_bridge_pkg::cmd_t cmd);
    wait_cmd_rdy();
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_read(output logic [7:0] data, output logic err);
    int waited;
    waited = 0;
    data   = '0;
    err    = 1'b0;
    while (read_rdy !== 1'b1 && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (read_rdy !== 1'b1)
    begin
      err_cnt++;
      $display("No read result arrived within %0d cycles", WAIT_LIMIT);
    end
    else
    begin
      data = read_data;
      err  = read_err;
      @(negedge clk);
      check_value("cmd_rdy after read_rdy", 32'(cmd_rdy), 32'd1);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Remote device
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin : remote_device
    logic [uart_bridge_pkg::FRAME_BITS-1:0] bits;
    logic [7:0]                             value;
    logic                                   data_pending;
    data_pending = 1'b0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge tx);
      frame_starts.push_back($time);
      repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of the start bit.
      bits[0] = tx;
      for (int i = 1; i < uart_bridge_pkg::FRAME_BITS; i++)
      begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        bits[i] = tx;
      end
      value = bits[8:1];
      check_value("tx start bit", 32'(bits[0]), 32'd0);
      check_value("tx parity bit", 32'(bits[9]), 32'(expected_parity(value)));
      check_value("tx stop bit", 32'(bits[10]), 32'd1);
      seen_bytes.push_back(value);
      if (data_pending)
      begin
        data_pending = 1'b0;
      end
      else if (value[7])
      begin
        data_pending = 1'b1;  // A write address is followed by its data frame.
      end
      else if (reply_mode != REPLY_NONE)
      begin
        repeat (REPLY_DELAY) @(negedge clk);
        send_frame(reply_byte, reply_mode == REPLY_BAD_PARITY);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset();
    check_value("tx", 32'(tx), 32'd1);
    check_value("cmd_rdy", 32'(cmd_rdy), 32'd1);
    check_value("read_rdy", 32'(read_rdy), 32'd0);
    check_value("read_data", 32'(read_data), 32'd0);
    check_value("read_err", 32'(read_err), 32'd0);
  endtask

  task automatic test_write(input int busy_pulses);
    uart_bridge_pkg::cmd_t cmd;
    int                    first;
    int                    pulses;
    int                    gap;
    cmd.wr   = 1'b1;
    cmd.addr = 7'($urandom);
    cmd.data = 8'($urandom);
    first    = seen_bytes.size();
    pulses   = read_pulses;
    issue_cmd(cmd);
    cmd_in = {1'b0, 7'($urandom), 8'($urandom)};
    repeat (busy_pulses)
    begin
      repeat (3 * CLKS_PER_BIT) @(negedge clk);
      check_value("cmd_rdy while busy", 32'(cmd_rdy), 32'd0);
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
    end
    wait_cmd_rdy();
    if (busy_pulses > 0)
    begin
      repeat (FRAME_CYCLES) @(negedge clk);  // Nothing more may go out.
    end
    check_value("write frames", 32'(seen_bytes.size() - first), 32'd2);
    check_value("read_rdy pulses", 32'(read_pulses - pulses), 32'd0);
    if (seen_bytes.size() >= first + 2)
    begin
      check_value("write address byte", 32'(seen_bytes[first]), 32'({cmd.wr, cmd.addr}));
      check_value("write data byte", 32'(seen_bytes[first + 1]), 32'(cmd.data));
      gap = int'((frame_starts[first + 1] - frame_starts[first]) / CLK_PERIOD) - FRAME_CYCLES;
      check_value("write gap cycles", 32'(gap), 32'(GAP_CYCLES));
    end
  endtask

  task automatic test_read(input int mode);
    uart_bridge_pkg::cmd_t cmd;
    int                    first;
    int                    pulses;
    logic [7:0]            data;
    logic                  err;
    cmd.wr     = 1'b0;
    cmd.addr   = 7'($urandom);
    cmd.data   = 8'($urandom);
    reply_mode = mode;
    reply_byte = 8'($urandom);
    first      = seen_bytes.size();
    pulses     = read_pulses;
    issue_cmd(cmd);
    wait_read(data, err);
    check_value("read frames", 32'(seen_bytes.size() - first), 32'd1);
    check_value("read_rdy pulses", 32'(read_pulses - pulses), 32'd1);
    if (seen_bytes.size() > first)
    begin
      check_value("read address byte", 32'(seen_bytes[first]), 32'({cmd.wr, cmd.addr}));
    end
    if (mode == REPLY_GOOD)
    begin
      check_value("read_data", 32'(data), 32'(reply_byte));
      check_value("read_err", 32'(err), 32'd0);
    end
    else if (mode == REPLY_BAD_PARITY)
    begin
      check_value("read_err", 32'(err), 32'd1);
    end
    else
    begin
      check_value("read_data", 32'(data), 32'd0);
      check_value("read_err", 32'(err), 32'd1);
    end
  endtask

  initial
  begin
    void'($urandom(32'hdfb7c4d8));
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    rx         = 1'b1;
    reply_mode = REPLY_GOOD;
    reply_byte = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset();
    test_write(0);
    test_read(REPLY_GOOD);
    test_read(REPLY_BAD_PARITY);
    test_read(REPLY_NONE);
    test_write(3);
    err_cnt += int'(dut0.chk0.fail_cnt);
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/uart_reg_bridge_chk.sv
`timescale 1ns/10ps
`default_nettype none

module uart_reg_bridge_chk (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic tx,
  input wire logic cmd_rdy,
  input wire logic read_rdy
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end of the run.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host side strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_read_rdy_single: assert property (
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy
  )
  else
  begin
    fail_cnt++;
    $error("read_rdy stayed high for two cycles");
  end

  a_read_rdy_busy: assert property (
    @(posedge clk) disable iff (!rst_n) read_rdy |-> !cmd_rdy
  )
  else
  begin
    fail_cnt++;
    $error("read_rdy came while cmd_rdy was high");
  end

  // An idle bridge keeps the line high.
  a_idle_line: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx
  )
  else
  begin
    fail_cnt++;
    $error("tx was low while cmd_rdy was high");
  end

endmodule

bind uart_reg_bridge uart_reg_bridge_chk chk0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx       (tx),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy)
);

`default_nettype wire

//--- hw/uart_reg_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module uart_reg_bridge #(
  parameter int CLKS_PER_BIT     = 434,
  parameter int GAP_CYCLES       = 100,
  parameter int RESP_WAIT_CYCLES = 20000
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire uart_bridge_pkg::cmd_t cmd_in,
  input  wire logic                  cmd_vld,
  input  wire logic                  rx,
  output logic                       tx,
  output logic                       cmd_rdy,
  output logic                       read_rdy,
  output logic [7:0]                 read_data,
  output logic                       read_err
);

  logic                       tx_start;
  logic [7:0]                 tx_byte;
  logic                       tx_done;
  logic                       rx_vld;
  logic                       rx_busy;
  uart_bridge_pkg::rx_frame_t rx_frame;

  uart_rx_frame #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_vld   (rx_vld),
    .rx_busy  (rx_busy),
    .rx_frame (rx_frame)
  );

  cmd_sequencer #(
    .GAP_CYCLES       (GAP_CYCLES),
    .RESP_WAIT_CYCLES (RESP_WAIT_CYCLES)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .tx_done   (tx_done),
    .rx_vld    (rx_vld),
    .rx_busy   (rx_busy),
    .rx_frame  (rx_frame),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

endmodule

`default_nettype wire

//--- hw/cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer #(
  parameter int GAP_CYCLES       = 100,
  parameter int RESP_WAIT_CYCLES = 20000
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire uart_bridge_pkg::cmd_t      cmd_in,
  input  wire logic                       cmd_vld,
  input  wire logic                       tx_done,
  input  wire logic                       rx_vld,
  input  wire logic                       rx_busy,
  input  wire uart_bridge_pkg::rx_frame_t rx_frame,
  output logic                            cmd_rdy,
  output logic                            tx_start,
  output logic [7:0]                      tx_byte,
  output logic                            read_rdy,
  output logic [7:0]                      read_data,
  output logic                            read_err
);

  localparam logic [2:0] ST_IDLE       = 3'd0;
  localparam logic [2:0] ST_SEND_ADDR  = 3'd1;
  localparam logic [2:0] ST_GAP        = 3'd2;
  localparam logic [2:0] ST_SEND_DATA  = 3'd3;
  localparam logic [2:0] ST_WAIT_REPLY = 3'd4;
  localparam logic [2:0] ST_RESULT     = 3'd5;

  // One counter covers both the gap and the reply timeout.
  localparam int CNT_MAX = (GAP_CYCLES > RESP_WAIT_CYCLES) ? GAP_CYCLES : RESP_WAIT_CYCLES;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  logic [2:0]            state;
  uart_bridge_pkg::cmd_t cmd_q;
  logic [CNT_W-1:0]      cnt;
  logic                  gap_end;
  logic                  wait_end;

  // The counter is loaded with 1 on tx_done so both limits land on the exact cycle.
  assign gap_end  = (cnt == CNT_W'(GAP_CYCLES - 1));
  assign wait_end = (cnt == CNT_W'(RESP_WAIT_CYCLES));

  assign tx_byte = (state == ST_SEND_DATA) ? cmd_q.data : {cmd_q.wr, cmd_q.addr};

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && cmd_vld)
    begin
      cmd_q <= cmd_in;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      cnt       <= '0;
      cmd_rdy   <= 1'b1;
      tx_start  <= 1'b0;
      read_rdy  <= 1'b0;
      read_data <= '0;
      read_err  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (cmd_vld)
          begin
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
            state    <= ST_SEND_ADDR;
          end
        end
        ST_SEND_ADDR:
        begin
          if (tx_done)
          begin
            cnt   <= CNT_W'(1);
            state <= cmd_q.wr ? ST_GAP : ST_WAIT_REPLY;
          end
        end
        ST_GAP:
        begin
          if (gap_end)
          begin
            tx_start <= 1'b1;
            state    <= ST_SEND_DATA;
          end
          else
          begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        ST_SEND_DATA:
        begin
          if (tx_done)
          begin
            cmd_rdy <= 1'b1;
            state   <= ST_IDLE;
          end
        end
        ST_WAIT_REPLY:
        begin
          if (rx_vld)
          begin
            read_data <= rx_frame.data;
            read_err  <= rx_frame.err;
            read_rdy  <= 1'b1;
            state     <= ST_RESULT;
          end
          else if (!rx_busy)  // A reply in progress holds the timer.
          begin
            if (wait_end)
            begin
              read_data <= '0;
              read_err  <= 1'b1;
              read_rdy  <= 1'b1;
              state     <= ST_RESULT;
            end
            else
            begin
              cnt <= cnt + CNT_W'(1);
            end
          end
        end
        ST_RESULT:
        begin
          cmd_rdy <= 1'b1;  // Ready again right after the read_rdy pulse.
          state   <= ST_IDLE;
        end
        default:
        begin
          cmd_rdy <= 1'b1;
          state   <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_rx_frame.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_frame #(
  parameter int CLKS_PER_BIT = 434
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   rx,
  output logic                        rx_vld,
  output logic                        rx_busy,
  output uart_bridge_pkg::rx_frame_t  rx_frame
);

  localparam int CNT_W    = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int HALF_BIT = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;

  logic             rx_s1;
  logic             rx_s2;
  logic             rx_s3;
  logic             fall;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic [7:0]       data_q;
  logic             par_err;
  logic             mid_start;
  logic             mid_bit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Synchronizer and edge detect
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_s3 <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_s3 <= rx_s2;  // Previous synchronized level.
    end
  end

  assign fall      = rx_s3 && !rx_s2;
  assign mid_start = (bit_cnt == 4'd0) && (clk_cnt == CNT_W'(HALF_BIT - 1));
  assign mid_bit   = (bit_cnt != 4'd0) && (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame sampling
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_busy <= 1'b0;
      rx_vld  <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else
    begin
      rx_vld <= 1'b0;
      if (!rx_busy)
      begin
        clk_cnt <= '0;
        bit_cnt <= '0;
        rx_busy <= fall;
      end
      else if (mid_start)
      begin
        clk_cnt <= '0;
        bit_cnt <= 4'd1;
        rx_busy <= !rx_s2;  // A high line here was only a glitch.
      end
      else if (mid_bit)
      begin
        clk_cnt <= '0;
        if (bit_cnt == 4'(uart_bridge_pkg::STOP_IDX))
        begin
          rx_busy <= 1'b0;
          rx_vld  <= 1'b1;
        end
        else
        begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
      else
      begin
        clk_cnt <= clk_cnt + CNT_W'(1);
      end
    end
  end

  // Payload capture follows the sample points above.
  always_ff @(posedge clk)
  begin
    if (rx_busy && mid_bit)
    begin
      if (bit_cnt < 4'(uart_bridge_pkg::PARITY_IDX))
      begin
        data_q <= {rx_s2, data_q[7:1]};  // LSB arrives first.
      end
      else if (bit_cnt == 4'(uart_bridge_pkg::PARITY_IDX))
      begin
        par_err <= (rx_s2 != uart_bridge_pkg::odd_parity(data_q));
      end
      else
      begin
        rx_frame.data <= data_q;
        rx_frame.err  <= par_err || !rx_s2;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_tx_frame.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx_frame #(
  parameter int CLKS_PER_BIT = 434
) (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       tx_start,
  input  wire logic [7:0] tx_byte,
  output logic            tx,
  output logic            tx_done
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  logic [uart_bridge_pkg::FRAME_BITS-1:0] shift_q;  // Bit 0 is on the line.
  logic [CNT_W-1:0]                       clk_cnt;
  logic [3:0]                             bit_cnt;
  logic                                   busy;
  logic                                   bit_end;
  logic                                   last_bit;

  assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign last_bit = (bit_cnt == 4'(uart_bridge_pkg::STOP_IDX));

  // High in the final cycle of the stop bit.
  assign tx_done = busy && bit_end && last_bit;
  assign tx      = shift_q[0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame shift register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q <= '1;
    end
    else if (tx_start && !busy)
    begin
      // Start bit goes out the cycle after tx_start.
      shift_q <= {1'b1, uart_bridge_pkg::odd_parity(tx_byte), tx_byte, 1'b0};
    end
    else if (busy && bit_end)
    begin
      shift_q <= {1'b1, shift_q[uart_bridge_pkg::FRAME_BITS-1:1]};  // Fill with idle.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (!busy)
    begin
      clk_cnt <= '0;
      bit_cnt <= '0;
      if (tx_start)
      begin
        busy <= 1'b1;
      end
    end
    else if (bit_end)
    begin
      clk_cnt <= '0;
      if (last_bit)
      begin
        busy <= 1'b0;
      end
      else
      begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end
    else
    begin
      clk_cnt <= clk_cnt + CNT_W'(1);
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_bridge_pkg.sv
`default_nettype none

package uart_bridge_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = DATA_BITS + 3;  // Start, data, parity and stop.

  // Bit positions inside one frame, counted from the start bit.
  localparam int FIRST_DATA_IDX = 1;
  localparam int PARITY_IDX     = FIRST_DATA_IDX + DATA_BITS;
  localparam int STOP_IDX       = PARITY_IDX + 1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host command and received frame
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The upper byte {wr, addr} is the address frame on the line.
  typedef struct packed {
    logic                 wr;    // 1 for a write.
    logic [6:0]           addr;
    logic [DATA_BITS-1:0] data;  // Unused by a read.
  } cmd_t;

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 err;   // Parity mismatch or low stop bit.
  } rx_frame_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Odd parity makes the total count of ones in data plus parity odd.
  function automatic logic odd_parity(input logic [DATA_BITS-1:0] value);
    return ~(^value);
  endfunction

endpackage

`default_nettype wire
